/* hw/immu_config.svh */
// Instruction MMU build-time geometry and feature constants
`ifndef IMMU_CONFIG_SVH
`define IMMU_CONFIG_SVH

// Virtual and physical address width
`define IMMU_AW 32

// MSR word and TLB entry word width
`define IMMU_DW 32

// Page offset bits, 8 KiB pages
`define IMMU_P_PAGE 13

// Page number width, 19 bits with the defaults
`define IMMU_VPN_DW (`IMMU_AW - `IMMU_P_PAGE)

// log2 of the TLB entry count, kept at or below the page number width
`define IMMU_P_SETS 4

// Low physical half treated as uncached when set
`define IMMU_UNC_SEG 1

`endif

/* hw/immu_pkg.sv */
// Instruction MMU shared types, MSR classes and TLB entry field layout
`include "immu_config.svh"

package immu_pkg;

   // MSR register class select
   typedef enum logic [1:0]
   {
      MSR_PSR   = 2'd0,
      MSR_IMMID = 2'd1,
      MSR_TLBL  = 2'd2,
      MSR_TLBH  = 2'd3
   } immu_msr_e;

   // Fetch exception code
   typedef enum logic [1:0]
   {
      EXC_NONE = 2'd0,
      // TLB miss
      EXC_ITM  = 2'd1,
      // Page fault on execute permission
      EXC_IPF  = 2'd2
   } immu_exc_e;

   // TLBL word layout
   // Valid bit
   localparam int TLBL_V = 0;
   // Tag sits in the top page-number-width bits
   localparam int TLBL_TAG_LSB = `IMMU_DW - `IMMU_VPN_DW;

   // TLBH word layout
   // Present, stored only
   localparam int TLBH_P = 0;
   // User execute
   localparam int TLBH_UX = 3;
   // Root execute
   localparam int TLBH_RX = 4;
   // Uncached page
   localparam int TLBH_UNC = 7;
   // Shared, stored only
   localparam int TLBH_S = 8;
   // Physical page number in the top bits
   localparam int TLBH_PPN_LSB = `IMMU_DW - `IMMU_VPN_DW;

   // PSR bits seen by the IMMU
   localparam int PSR_IMME = 0;
   localparam int PSR_RM = 1;

endpackage

/* hw/immu_tlb_ram.sv */
// One TLB bank as a register file with registered read and one write port
`include "immu_config.svh"

module immu_tlb_ram
#(
   parameter int AW = `IMMU_P_SETS,
   parameter int DW = `IMMU_DW
)
(
   input  logic          clk,
   input  logic          re,
   input  logic [AW-1:0] raddr,
   input  logic          we,
   input  logic [AW-1:0] waddr,
   input  logic [DW-1:0] wdata,
   output logic [DW-1:0] rdata
);

   // Entry storage
   logic [DW-1:0] mem [2**AW];

   // Synchronous write port
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read, held while re is low
   // Same-edge write to the read index gives the old word
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

endmodule

/* hw/immu_msr_decode.sv */
// IMMU MSR decode holding the PSR bits and steering TLB bank writes
`include "immu_config.svh"

module immu_msr_decode
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      msr_we,
   input  immu_pkg::immu_msr_e       msr_sel,
   input  logic [`IMMU_P_SETS-1:0]   msr_idx,
   input  logic [`IMMU_DW-1:0]       msr_wdata,
   output logic [`IMMU_DW-1:0]       msr_rdata,
   output logic                      psr_imme,
   output logic                      psr_rm,
   output logic                      tlbl_we,
   output logic                      tlbh_we,
   output logic [`IMMU_P_SETS-1:0]   tlb_widx,
   output logic [`IMMU_DW-1:0]       tlb_wdata
);

   import immu_pkg::*;

   // IMMID reports the set-bits value in its low three bits
   localparam logic [`IMMU_DW-1:0] IMMID_VAL =
      {{(`IMMU_DW-3){1'b0}}, 3'(`IMMU_P_SETS)};

   logic psr_we;

   // PSR write strobe
   assign psr_we = msr_we & (msr_sel == MSR_PSR);

   // MMU enable and root mode
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         psr_imme <= 1'b0;
         psr_rm   <= 1'b0;
      end
      else if (psr_we)
      begin
         psr_imme <= msr_wdata[PSR_IMME];
         psr_rm   <= msr_wdata[PSR_RM];
      end
   end

   // One bank strobe per write, never both
   assign tlbl_we = msr_we & (msr_sel == MSR_TLBL);
   assign tlbh_we = msr_we & (msr_sel == MSR_TLBH);

   // Index and data shared by both banks
   assign tlb_widx  = msr_idx;
   assign tlb_wdata = msr_wdata;

   // Read-back mux
   always_comb
   begin
      msr_rdata = '0;
      case (msr_sel)
         MSR_PSR:
         begin
            msr_rdata[PSR_IMME] = psr_imme;
            msr_rdata[PSR_RM]   = psr_rm;
         end
         MSR_IMMID:
         begin
            msr_rdata = IMMID_VAL;
         end
         // TLB banks are write-only here
         default:
         begin
            msr_rdata = '0;
         end
      endcase
   end

endmodule

/* hw/immu_lookup.sv */
// IMMU lookup stage capturing the fetch context and checking tag and permission
`include "immu_config.svh"

module immu_lookup
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      re,
   input  logic [`IMMU_VPN_DW-1:0]   vpn,
   input  logic                      psr_imme,
   input  logic                      psr_rm,
   input  logic                      tlbl_we,
   input  logic                      tlbh_we,
   input  logic [`IMMU_P_SETS-1:0]   tlb_widx,
   input  logic [`IMMU_DW-1:0]       tlb_wdata,
   output logic                      imme_q,
   output logic [`IMMU_VPN_DW-1:0]   vpn_q,
   output logic                      hit,
   output logic                      perm_ok,
   output logic [`IMMU_VPN_DW-1:0]   entry_ppn,
   output logic                      entry_unc
);

   import immu_pkg::*;

   logic                      rm_q;
   logic [`IMMU_P_SETS-1:0]   set_idx;
   logic [`IMMU_DW-1:0]       tlbl_q;
   logic [`IMMU_DW-1:0]       tlbh_q;
   logic                      entry_v;
   logic [`IMMU_VPN_DW-1:0]   entry_tag;
   logic                      entry_ux;
   logic                      entry_rx;

   // Direct-mapped index from the low page bits
   assign set_idx = vpn[`IMMU_P_SETS-1:0];

   // Fetch context sampled with the bank read
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         imme_q <= 1'b0;
         rm_q   <= 1'b0;
         vpn_q  <= '0;
      end
      else if (re)
      begin
         imme_q <= psr_imme;
         rm_q   <= psr_rm;
         vpn_q  <= vpn;
      end
   end

   // Tag and valid bank
   immu_tlb_ram u_tlb_l
   (
      .clk   (clk),
      .re    (re),
      .raddr (set_idx),
      .we    (tlbl_we),
      .waddr (tlb_widx),
      .wdata (tlb_wdata),
      .rdata (tlbl_q)
   );

   // PPN and attribute bank
   immu_tlb_ram u_tlb_h
   (
      .clk   (clk),
      .re    (re),
      .raddr (set_idx),
      .we    (tlbh_we),
      .waddr (tlb_widx),
      .wdata (tlb_wdata),
      .rdata (tlbh_q)
   );

   // Entry unpack
   assign entry_v   = tlbl_q[TLBL_V];
   assign entry_tag = tlbl_q[`IMMU_DW-1:TLBL_TAG_LSB];
   assign entry_ux  = tlbh_q[TLBH_UX];
   assign entry_rx  = tlbh_q[TLBH_RX];
   assign entry_unc = tlbh_q[TLBH_UNC];
   assign entry_ppn = tlbh_q[`IMMU_DW-1:TLBH_PPN_LSB];

   // Full page number compared against the tag
   assign hit = entry_v & (entry_tag == vpn_q);

   // Root mode uses RX, user mode UX
   assign perm_ok = rm_q ? entry_rx : entry_ux;

endmodule

/* hw/immu_result.sv */
// IMMU result stage forming page number, exception code and uncached flag
`include "immu_config.svh"

module immu_result
(
   input  logic                      imme_q,
   input  logic [`IMMU_VPN_DW-1:0]   vpn_q,
   input  logic                      hit,
   input  logic                      perm_ok,
   input  logic [`IMMU_VPN_DW-1:0]   entry_ppn,
   input  logic                      entry_unc,
   output logic [`IMMU_VPN_DW-1:0]   ppn,
   output immu_pkg::immu_exc_e       exc,
   output logic                      uncached
);

   import immu_pkg::*;

   logic tlb_unc;
   logic seg_unc;

   // Miss has priority over the permission fault
   always_comb
   begin
      if (imme_q && !hit)
         exc = EXC_ITM;
      else if (imme_q && !perm_ok)
         exc = EXC_IPF;
      else
         exc = EXC_NONE;
   end

   // Identity mapping with the MMU off
   assign ppn = imme_q ? entry_ppn : vpn_q;

   // Page attribute only counts on a clean translated hit
   assign tlb_unc = imme_q & hit & perm_ok & entry_unc;

   // Low half of physical space, whether or not translated
   generate
      if (`IMMU_UNC_SEG != 0)
      begin : g_unc_seg
         assign seg_unc = (exc == EXC_NONE) & ~ppn[`IMMU_VPN_DW-1];
      end
      else
      begin : g_no_unc_seg
         assign seg_unc = 1'b0;
      end
   endgenerate

   assign uncached = tlb_unc | seg_unc;

endmodule

/* hw/immu_top.sv */
// Instruction MMU top joining MSR decode, TLB lookup and result forming
`include "immu_config.svh"

module immu_top
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      re,
   input  logic [`IMMU_VPN_DW-1:0]   vpn,
   input  logic                      msr_we,
   input  immu_pkg::immu_msr_e       msr_sel,
   input  logic [`IMMU_P_SETS-1:0]   msr_idx,
   input  logic [`IMMU_DW-1:0]       msr_wdata,
   output logic [`IMMU_VPN_DW-1:0]   ppn,
   output immu_pkg::immu_exc_e       exc,
   output logic                      uncached,
   output logic [`IMMU_DW-1:0]       msr_rdata
);

   // Decode to lookup
   logic                      psr_imme;
   logic                      psr_rm;
   logic                      tlbl_we;
   logic                      tlbh_we;
   logic [`IMMU_P_SETS-1:0]   tlb_widx;
   logic [`IMMU_DW-1:0]       tlb_wdata;

   // Lookup to result
   logic                      imme_q;
   logic [`IMMU_VPN_DW-1:0]   vpn_q;
   logic                      hit;
   logic                      perm_ok;
   logic [`IMMU_VPN_DW-1:0]   entry_ppn;
   logic                      entry_unc;

   immu_msr_decode u_decode
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .msr_we    (msr_we),
      .msr_sel   (msr_sel),
      .msr_idx   (msr_idx),
      .msr_wdata (msr_wdata),
      .msr_rdata (msr_rdata),
      .psr_imme  (psr_imme),
      .psr_rm    (psr_rm),
      .tlbl_we   (tlbl_we),
      .tlbh_we   (tlbh_we),
      .tlb_widx  (tlb_widx),
      .tlb_wdata (tlb_wdata)
   );

   immu_lookup u_lookup
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .re        (re),
      .vpn       (vpn),
      .psr_imme  (psr_imme),
      .psr_rm    (psr_rm),
      .tlbl_we   (tlbl_we),
      .tlbh_we   (tlbh_we),
      .tlb_widx  (tlb_widx),
      .tlb_wdata (tlb_wdata),
      .imme_q    (imme_q),
      .vpn_q     (vpn_q),
      .hit       (hit),
      .perm_ok   (perm_ok),
      .entry_ppn (entry_ppn),
      .entry_unc (entry_unc)
   );

   immu_result u_result
   (
      .imme_q    (imme_q),
      .vpn_q     (vpn_q),
      .hit       (hit),
      .perm_ok   (perm_ok),
      .entry_ppn (entry_ppn),
      .entry_unc (entry_unc),
      .ppn       (ppn),
      .exc       (exc),
      .uncached  (uncached)
   );

endmodule

/* sim/immu_tb.sv */
// Instruction MMU testbench with a shadow TLB model and assertion-based checks
`include "immu_config.svh"

module immu_tb;

   import immu_pkg::*;

   localparam int DW = `IMMU_DW;
   localparam int VW = `IMMU_VPN_DW;
   localparam int SW = `IMMU_P_SETS;
   localparam int SETS = 2 ** SW;
   // Stimulus runs near 950 cycles, limit is about four times that
   localparam int TIMEOUT_CYCLES = 4000;

   logic            clk;
   logic            arst_n;
   logic            re;
   logic [VW-1:0]   vpn;
   logic            msr_we;
   immu_msr_e       msr_sel;
   logic [SW-1:0]   msr_idx;
   logic [DW-1:0]   msr_wdata;
   logic [VW-1:0]   ppn;
   immu_exc_e       exc;
   logic            uncached;
   logic [DW-1:0]   msr_rdata;

   // Shadow of DUT state, follows the MSR writes seen at each edge
   logic [DW-1:0]   sh_l [SETS];
   logic [DW-1:0]   sh_h [SETS];
   logic            sh_imme;
   logic            sh_rm;

   // Expected outputs, held until the next lookup like the DUT
   logic [VW-1:0]   exp_ppn;
   immu_exc_e       exp_exc;
   logic            exp_unc;
   logic [DW-1:0]   exp_rdata;

   // Entries as programmed by the stimulus
   logic [DW-1:0]   ent_l [SETS];
   logic [DW-1:0]   ent_h [SETS];

   int              cycles;

   immu_top immu_top_inst
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .re        (re),
      .vpn       (vpn),
      .msr_we    (msr_we),
      .msr_sel   (msr_sel),
      .msr_idx   (msr_idx),
      .msr_wdata (msr_wdata),
      .ppn       (ppn),
      .exc       (exc),
      .uncached  (uncached),
      .msr_rdata (msr_rdata)
   );

   always #2 clk = ~clk;

   // Reference model, one lookup per edge with re high
   always @(posedge clk)
   begin : model
      logic [DW-1:0] l;
      logic [DW-1:0] h;
      logic          hit;
      logic          allow;
      logic [VW-1:0] p;
      immu_exc_e     e;
      if (!arst_n)
      begin
         sh_imme <= 1'b0;
         sh_rm   <= 1'b0;
         exp_ppn <= '0;
         exp_exc <= EXC_NONE;
         // Page 0 sits in the low segment
         exp_unc <= (`IMMU_UNC_SEG != 0);
      end
      else
      begin
         if (re)
         begin
            l = sh_l[vpn[SW-1:0]];
            h = sh_h[vpn[SW-1:0]];
            hit = l[TLBL_V] && (l[DW-1:TLBL_TAG_LSB] == vpn);
            allow = sh_rm ? h[TLBH_RX] : h[TLBH_UX];
            if (!sh_imme)
               e = EXC_NONE;
            else if (!hit)
               e = EXC_ITM;
            else if (!allow)
               e = EXC_IPF;
            else
               e = EXC_NONE;
            p = sh_imme ? h[DW-1:TLBH_PPN_LSB] : vpn;
            exp_ppn <= p;
            exp_exc <= e;
            exp_unc <= (e == EXC_NONE) &&
                       ((sh_imme && h[TLBH_UNC]) || (`IMMU_UNC_SEG != 0 && !p[VW-1]));
         end
         // Writes land after the read of the same edge
         if (msr_we)
         begin
            case (msr_sel)
               MSR_PSR:
               begin
                  sh_imme <= msr_wdata[PSR_IMME];
                  sh_rm   <= msr_wdata[PSR_RM];
               end
               MSR_TLBL: sh_l[msr_idx] <= msr_wdata;
               MSR_TLBH: sh_h[msr_idx] <= msr_wdata;
               default:  sh_imme <= sh_imme;
            endcase
         end
      end
   end

   // MSR read data from the selected class
   always_comb
   begin
      exp_rdata = '0;
      if (msr_sel == MSR_PSR)
      begin
         exp_rdata[PSR_IMME] = sh_imme;
         exp_rdata[PSR_RM]   = sh_rm;
      end
      else if (msr_sel == MSR_IMMID)
      begin
         exp_rdata = DW'(SW);
      end
   end

   task automatic report_mismatch(input string field, input logic [DW-1:0] got,
                                  input logic [DW-1:0] want);
      $display("ERROR %0t: %s is %h, expected %h", $time, field, got, want);
      $display("TEST FAILED");
      $fatal(1, "output mismatch");
   endtask

   assert property (@(posedge clk) disable iff (!arst_n) ppn == exp_ppn)
   else report_mismatch("ppn", DW'($sampled(ppn)), DW'($sampled(exp_ppn)));
   assert property (@(posedge clk) disable iff (!arst_n) exc == exp_exc)
   else report_mismatch("exc", DW'($sampled(exc)), DW'($sampled(exp_exc)));
   assert property (@(posedge clk) disable iff (!arst_n) uncached == exp_unc)
   else report_mismatch("uncached", DW'($sampled(uncached)), DW'($sampled(exp_unc)));
   assert property (@(posedge clk) disable iff (!arst_n) msr_rdata == exp_rdata)
   else report_mismatch("msr_rdata", $sampled(msr_rdata), $sampled(exp_rdata));

   // Run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic fetch(input logic [VW-1:0] v);
      @(posedge clk);
      msr_we <= 1'b0;
      re     <= 1'b1;
      vpn    <= v;
   endtask

   task automatic msr_write(input immu_msr_e sel, input logic [SW-1:0] idx,
                            input logic [DW-1:0] data);
      @(posedge clk);
      re        <= 1'b0;
      msr_we    <= 1'b1;
      msr_sel   <= sel;
      msr_idx   <= idx;
      msr_wdata <= data;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         re     <= 1'b0;
         msr_we <= 1'b0;
      end
   endtask

   // Park the read mux on one class for a couple of cycles
   task automatic select_read(input immu_msr_e sel);
      @(posedge clk);
      re      <= 1'b0;
      msr_we  <= 1'b0;
      msr_sel <= sel;
      idle(2);
   endtask

   // PSR write, then one idle cycle so msr_rdata is checked
   task automatic set_psr(input logic imme, input logic rm);
      msr_write(MSR_PSR, '0, DW'({rm, imme}));
      idle(1);
   endtask

   task automatic write_entry(input logic [SW-1:0] idx, input logic [DW-1:0] l,
                              input logic [DW-1:0] h);
      msr_write(MSR_TLBL, idx, l);
      msr_write(MSR_TLBH, idx, h);
      ent_l[idx] = l;
      ent_h[idx] = h;
   endtask

   // Valid entry with random tag, PPN and attributes
   task automatic program_random(input int i);
      logic [DW-1:0] l;
      logic [DW-1:0] h;
      l = $urandom;
      h = $urandom;
      l[TLBL_V] = 1'b1;
      // Tag low bits must select this set
      l[TLBL_TAG_LSB +: SW] = SW'(i);
      write_entry(SW'(i), l, h);
   endtask

   function automatic logic [VW-1:0] tag_of(input int i);
      return ent_l[i][DW-1:TLBL_TAG_LSB];
   endfunction

   function automatic int rand_set();
      return int'($urandom % SETS);
   endfunction

   initial
   begin : stimulus
      logic [VW-1:0]    v;
      logic [VW-SW-1:0] flip;
      logic [DW-1:0]    w;
      int               i;
      void'($urandom(32'h91dbd995));
      clk       = 1'b0;
      arst_n    = 1'b0;
      re        = 1'b0;
      vpn       = '0;
      msr_we    = 1'b0;
      msr_sel   = MSR_PSR;
      msr_idx   = '0;
      msr_wdata = '0;
      cycles    = 0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      // Reset values, IMMID geometry, PSR zero
      idle(2);
      select_read(MSR_IMMID);
      select_read(MSR_PSR);

      // MMU off, identity pages back to back
      repeat (300) fetch(VW'($urandom));
      idle(2);

      for (i = 0; i < SETS; i++)
         program_random(i);

      // Hits in root mode, then in user mode
      set_psr(1'b1, 1'b1);
      repeat (128) fetch(tag_of(rand_set()));
      set_psr(1'b1, 1'b0);
      repeat (128) fetch(tag_of(rand_set()));

      // Same set, different tag
      repeat (96)
      begin
         i = rand_set();
         v = tag_of(i);
         flip = (VW-SW)'($urandom);
         if (flip == '0)
            flip = 1;
         v[VW-1:SW] = v[VW-1:SW] ^ flip;
         fetch(v);
      end

      // Valid bit cleared, then restored
      for (i = 0; i < SETS; i += 4)
      begin
         w = ent_l[i];
         w[TLBL_V] = 1'b0;
         write_entry(SW'(i), w, ent_h[i]);
         fetch(tag_of(i));
         w[TLBL_V] = 1'b1;
         write_entry(SW'(i), w, ent_h[i]);
      end

      // Rewritten entries seen by later lookups
      repeat (24)
      begin
         i = rand_set();
         program_random(i);
         fetch(tag_of(i));
         fetch(VW'($urandom));
      end

      // PSR change between two lookups of one page
      repeat (16)
      begin
         v = tag_of(rand_set());
         fetch(v);
         set_psr(1'b0, 1'($urandom));
         fetch(v);
         set_psr(1'b1, 1'($urandom));
         fetch(v);
      end

      idle(4);
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* immu_top.f */
+incdir+hw
hw/immu_pkg.sv
hw/immu_tlb_ram.sv
hw/immu_msr_decode.sv
hw/immu_lookup.sv
hw/immu_result.sv
hw/immu_top.sv
sim/immu_tb.sv

/* Makefile */
# Verilator build and run for the instruction MMU testbench

VERILATOR ?= verilator
TOP       ?= immu_tb
FLIST     ?= immu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(shell grep -v '^+' $(FLIST)) hw/immu_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx 'TEST PASSED' $(LOG); then \
		echo "Simulation ok"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
